/* sim.f */
rtl/daq_pkg.sv
rtl/acq_readout.sv
rtl/scurve_scan.sv
rtl/daq_source_select.sv
rtl/usb_data_fifo.sv
rtl/daq_top.sv
verif/tb_clock_gen.sv
verif/daq_properties.sv
verif/tb_daq_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sim.f --top-module tb_daq_top -Mdir obj_dir

./obj_dir/Vtb_daq_top > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failures found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
if ! grep -q "All tests passed!" sim.log; then
    echo "simulation stopped before the end of the tests"
    exit 1
fi
echo "simulation passed"

/* verif/tb_daq_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_daq_top;

    localparam int CLK_NS     = 20;
    localparam int DAC_LAST   = 3;
    localparam int FIFO_DEPTH = 16;
    localparam int CPT_MAX    = 40;     // trigger window in cycles
    localparam int POP_WAIT   = 8;      // cycles a stored word may take to appear
    // worst case cycles per test, one idle slot per serial bit
    localparam int ACQ_CYC  = 2 * 2 * 16 + 20;
    localparam int PART_CYC = 2 * 9 + 20;
    localparam int SCAN_CYC = (DAC_LAST + 1) * (CPT_MAX + 4) + 2 * 8 + 20;
    localparam int OVF_CYC  = (FIFO_DEPTH + 3) * 2 * 16 + 2 * FIFO_DEPTH + 20;
    localparam int RUN_NS   = 2 * (20 + ACQ_CYC + PART_CYC + SCAN_CYC + OVF_CYC) * CLK_NS;

    logic           clk;
    logic           arst_n;
    daq_pkg::mode_t mode;
    logic           acq_enable;
    logic [7:0]     header;
    logic           dout_b;
    logic           transmiton_b;
    logic           test_start;
    daq_pkg::word_t cpt_max;
    logic           trig_b;
    daq_pkg::dac_t  usb_dac_vth;
    logic           fifo_rd_en;
    daq_pkg::dac_t  dac_vth;
    logic           test_done;
    daq_pkg::word_t fifo_rd_data;
    logic           fifo_empty;
    logic           overflow;
    integer         seed;

    tb_clock_gen #(.PERIOD_NS(CLK_NS)) u_clock_gen (.clk(clk));

    daq_top #(
        .DAC_LAST   (daq_pkg::dac_t'(DAC_LAST)),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut (
        .clk(clk), .arst_n(arst_n), .mode(mode), .acq_enable(acq_enable),
        .header(header), .dout_b(dout_b), .transmiton_b(transmiton_b),
        .test_start(test_start), .cpt_max(cpt_max), .trig_b(trig_b),
        .usb_dac_vth(usb_dac_vth), .fifo_rd_en(fifo_rd_en), .dac_vth(dac_vth),
        .test_done(test_done), .fifo_rd_data(fifo_rd_data),
        .fifo_empty(fifo_empty), .overflow(overflow)
    );

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("ERR %s: got 0x%h, expected 0x%h", name, actual, expected));
        end
    endtask

    function automatic logic [31:0] next_rand();
        next_rand = $random(seed);
    endfunction

    // msb first, active low data, random idle slots with transmiton_b high
    task automatic shift_bits(input logic [15:0] data, input int nbits);
        int i;
        for (i = 0; i < nbits; i++) begin
            if (next_rand() % 32'd4 == 32'd0) begin
                @(negedge clk);
                transmiton_b = 1'b1;
                dout_b       = 1'b1;
            end
            @(negedge clk);
            transmiton_b = 1'b0;
            dout_b       = ~data[15 - i];
        end
        @(negedge clk);
        transmiton_b = 1'b1;   // line back to idle
        dout_b       = 1'b1;
    endtask

    // waits for a word, checks the head and pops it
    task automatic pop_word(input logic [15:0] expected);
        int waited;
        waited = 0;
        while (fifo_empty) begin
            if (waited == POP_WAIT) abort_run("fifo stayed empty while a word was due");
            @(negedge clk);
            waited++;
        end
        check_value("fifo_rd_data", 32'(fifo_rd_data), 32'(expected));
        fifo_rd_en = 1'b1;
        @(negedge clk);
        fifo_rd_en = 1'b0;
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////
    task automatic check_reset_state();
        check_value("fifo_empty", 32'(fifo_empty), 32'd1);
        check_value("overflow", 32'(overflow), 32'd0);
        check_value("test_done", 32'(test_done), 32'd0);
    endtask

    task automatic test_acq_words();
        logic [7:0]  hdr;
        logic [15:0] w0;
        logic [15:0] w1;
        hdr        = 8'(next_rand());
        w0         = 16'(next_rand());
        w1         = 16'(next_rand());
        mode       = daq_pkg::MODE_ACQ;
        header     = hdr;
        acq_enable = 1'b1;                   // header word on this rise
        shift_bits(w0, 16);
        repeat (2) @(negedge clk);           // gap between words
        shift_bits(w1, 16);
        acq_enable = 1'b0;
        pop_word({daq_pkg::HEADER_TAG, hdr});
        pop_word(w0);
        pop_word(w1);
        check_value("fifo_empty", 32'(fifo_empty), 32'd1);
    endtask

    task automatic test_partial_word();
        logic [7:0] hdr;
        hdr = 8'(next_rand());
        repeat (2) @(negedge clk);           // enable low long enough for a new rise
        header     = hdr;
        acq_enable = 1'b1;
        shift_bits(16'(next_rand()), 9);
        acq_enable = 1'b0;                   // 9 bits dropped
        pop_word({daq_pkg::HEADER_TAG, hdr});
        repeat (3) @(negedge clk);
        check_value("fifo_empty", 32'(fifo_empty), 32'd1);
    endtask

    task automatic test_scurve_scan();
        logic [15:0] exp_q[$];
        logic [15:0] code_word;
        int          code;
        int          pulses;
        int          p;
        int          waited;
        mode       = daq_pkg::MODE_SCURVE;
        cpt_max    = 16'(CPT_MAX);
        test_start = 1'b1;
        @(negedge clk);
        test_start = 1'b0;
        for (code = 0; code <= DAC_LAST; code++) begin
            code_word = {daq_pkg::SCAN_TAG, 10'(code)};
            waited    = 0;
            while (!(dut.scan_word_valid && dut.scan_word == code_word)) begin
                if (waited == CPT_MAX + 8) abort_run("scan produced no code word for a step");
                @(negedge clk);
                waited++;
            end
            check_value("dac_vth", 32'(dac_vth), 32'(code));
            pulses = int'(next_rand() % 32'd9);   // 0 to 8 triggers
            exp_q.push_back(code_word);
            exp_q.push_back(16'(pulses));
            @(negedge clk);                       // window counting from here
            for (p = 0; p < pulses; p++) begin
                trig_b = 1'b0;
                repeat (2) @(negedge clk);
                trig_b = 1'b1;
                repeat (2) @(negedge clk);
            end
        end
        waited = 0;
        while (!test_done) begin
            if (waited == 2 * CPT_MAX) abort_run("test_done never pulsed after the last step");
            @(negedge clk);
            waited++;
        end
        while (exp_q.size() > 0) begin
            pop_word(exp_q.pop_front());
        end
        check_value("fifo_empty", 32'(fifo_empty), 32'd1);
    endtask

    task automatic test_dac_source();
        daq_pkg::dac_t vth;
        vth         = 10'(next_rand());
        mode        = daq_pkg::MODE_ACQ;
        usb_dac_vth = vth;
        @(negedge clk);
        check_value("dac_vth", 32'(dac_vth), 32'(vth));        // host value
        mode = daq_pkg::MODE_SCURVE;
        @(negedge clk);
        check_value("dac_vth", 32'(dac_vth), 32'(DAC_LAST));   // scan holds last code
        mode = daq_pkg::MODE_ACQ;
    endtask

    task automatic test_overflow();
        logic [15:0] exp_q[$];
        logic [15:0] w;
        int          i;
        check_value("overflow", 32'(overflow), 32'd0);
        header     = 8'(next_rand());
        acq_enable = 1'b1;
        exp_q.push_back({daq_pkg::HEADER_TAG, header});
        // header plus FIFO_DEPTH+3 data words, four more than fit
        for (i = 0; i < FIFO_DEPTH + 3; i++) begin
            w = 16'(next_rand());
            if (exp_q.size() < FIFO_DEPTH) exp_q.push_back(w);
            shift_bits(w, 16);
        end
        acq_enable = 1'b0;
        repeat (2) @(negedge clk);
        check_value("overflow", 32'(overflow), 32'd1);
        while (exp_q.size() > 0) begin
            pop_word(exp_q.pop_front());
        end
        check_value("fifo_empty", 32'(fifo_empty), 32'd1);
    endtask

    ////////////////////////////////////////
    // run control
    ////////////////////////////////////////
    initial begin
        #(RUN_NS);
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        seed         = 32'he363;
        arst_n       = 1'b0;
        mode         = daq_pkg::MODE_ACQ;
        acq_enable   = 1'b0;
        header       = '0;
        dout_b       = 1'b1;     // active low lines idle high
        transmiton_b = 1'b1;
        test_start   = 1'b0;
        cpt_max      = '0;
        trig_b       = 1'b1;
        usb_dac_vth  = '0;
        fifo_rd_en   = 1'b0;
        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        check_reset_state();
        test_acq_words();
        test_partial_word();
        test_scurve_scan();
        test_dac_source();
        test_overflow();
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/daq_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module daq_properties (
    input logic clk,
    input logic arst_n,
    input logic fifo_rd_en,
    input logic fifo_full,
    input logic fifo_empty,
    input logic test_done,
    input logic overflow
);

    // a write while full would push the count past depth and drop full
    no_write_when_full: assert property (
        @(posedge clk) disable iff (!arst_n) (fifo_full && !fifo_rd_en) |=> fifo_full
    ) else $error("fifo written while full");

    full_empty_exclusive: assert property (
        @(posedge clk) disable iff (!arst_n) !(fifo_full && fifo_empty)
    ) else $error("fifo full and empty at once");

    // single cycle done pulse
    done_one_cycle: assert property (
        @(posedge clk) disable iff (!arst_n) test_done |=> !test_done
    ) else $error("test_done high for two cycles");

    overflow_sticky: assert property (
        @(posedge clk) disable iff (!arst_n) overflow |=> overflow
    ) else $error("overflow cleared outside reset");

endmodule

bind daq_top daq_properties u_daq_properties (
    .clk        (clk),
    .arst_n     (arst_n),
    .fifo_rd_en (fifo_rd_en),
    .fifo_full  (fifo_full),
    .fifo_empty (fifo_empty),
    .test_done  (test_done),
    .overflow   (overflow)
);

`default_nettype wire

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;    // 50 % duty
    end

endmodule

`default_nettype wire

/* rtl/daq_top.sv */
`timescale 1ns/1ps
`default_nettype none

module daq_top #(
    parameter daq_pkg::dac_t DAC_LAST   = '1,   // final scan code
    parameter int            FIFO_DEPTH = 16
) (
    input  logic           clk,
    input  logic           arst_n,
    input  daq_pkg::mode_t mode,           // change only with both sources idle
    // acquisition readout pins
    input  logic           acq_enable,
    input  logic [7:0]     header,
    input  logic           dout_b,
    input  logic           transmiton_b,
    // s-curve control
    input  logic           test_start,
    input  daq_pkg::word_t cpt_max,
    input  logic           trig_b,
    input  daq_pkg::dac_t  usb_dac_vth,
    // host side
    input  logic           fifo_rd_en,
    output daq_pkg::dac_t  dac_vth,
    output logic           test_done,
    output daq_pkg::word_t fifo_rd_data,
    output logic           fifo_empty,
    output logic           overflow
);

    daq_pkg::word_t acq_word;
    logic           acq_word_valid;
    daq_pkg::word_t scan_word;
    logic           scan_word_valid;
    daq_pkg::dac_t  scan_dac;
    logic           fifo_wr_en;
    daq_pkg::word_t fifo_wr_data;
    logic           fifo_full;

    ////////////////////////////////////////
    // data sources
    ////////////////////////////////////////
    acq_readout u_acq_readout (
        .clk            (clk),
        .arst_n         (arst_n),
        .acq_enable     (acq_enable),
        .header         (header),
        .dout_b         (dout_b),
        .transmiton_b   (transmiton_b),
        .acq_word       (acq_word),
        .acq_word_valid (acq_word_valid)
    );

    scurve_scan #(
        .DAC_LAST (DAC_LAST)
    ) u_scurve_scan (
        .clk             (clk),
        .arst_n          (arst_n),
        .test_start      (test_start),
        .cpt_max         (cpt_max),
        .trig_b          (trig_b),
        .scan_word       (scan_word),
        .scan_word_valid (scan_word_valid),
        .scan_dac        (scan_dac),
        .test_done       (test_done)
    );

    ////////////////////////////////////////
    // selector and usb data fifo
    ////////////////////////////////////////
    daq_source_select u_source_select (
        .clk             (clk),
        .arst_n          (arst_n),
        .mode            (mode),
        .acq_word        (acq_word),
        .scan_word       (scan_word),
        .acq_word_valid  (acq_word_valid),
        .scan_word_valid (scan_word_valid),
        .usb_dac_vth     (usb_dac_vth),
        .scan_dac        (scan_dac),
        .fifo_full       (fifo_full),
        .fifo_wr_en      (fifo_wr_en),
        .fifo_wr_data    (fifo_wr_data),
        .dac_vth         (dac_vth),
        .overflow        (overflow)
    );

    usb_data_fifo #(
        .DEPTH     (FIFO_DEPTH),
        .payload_t (daq_pkg::word_t)
    ) u_usb_data_fifo (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr_en   (fifo_wr_en),
        .wr_data (fifo_wr_data),
        .rd_en   (fifo_rd_en),
        .rd_data (fifo_rd_data),
        .full    (fifo_full),
        .empty   (fifo_empty)
    );

endmodule

`default_nettype wire

/* rtl/usb_data_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_data_fifo #(
    parameter int  DEPTH     = 16,
    parameter type payload_t = daq_pkg::word_t
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     wr_en,      // caller keeps it low while full
    input  payload_t wr_data,
    input  logic     rd_en,      // pop head word
    output payload_t rd_data,    // head word, fall-through
    output logic     full,
    output logic     empty
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);
    localparam logic [AW-1:0] PTR_LAST = AW'(DEPTH - 1);

    payload_t       mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [CW-1:0]  count;       // words stored
    logic           rd_ok;       // pop that really happens

    assign rd_ok = rd_en & ~empty;

    ////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // idle or write with pop
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    assign rd_data = mem[rd_ptr];            // visible one cycle after write
    assign full    = (count == CW'(DEPTH));
    assign empty   = (count == '0);

endmodule

`default_nettype wire

/* rtl/daq_source_select.sv */
`timescale 1ns/1ps
`default_nettype none

module daq_source_select (
    input  logic           clk,
    input  logic           arst_n,
    input  daq_pkg::mode_t mode,
    input  daq_pkg::word_t acq_word,
    input  daq_pkg::word_t scan_word,
    input  logic           acq_word_valid,
    input  logic           scan_word_valid,
    input  daq_pkg::dac_t  usb_dac_vth,      // host threshold
    input  daq_pkg::dac_t  scan_dac,         // scan threshold
    input  logic           fifo_full,
    output logic           fifo_wr_en,
    output daq_pkg::word_t fifo_wr_data,
    output daq_pkg::dac_t  dac_vth,          // to asic dac
    output logic           overflow          // sticky, word lost
);

    logic scurve_sel;
    logic src_valid;   // strobe of the active source

    assign scurve_sel = (mode == daq_pkg::MODE_SCURVE);

    // source mux
    assign src_valid    = scurve_sel ? scan_word_valid : acq_word_valid;
    assign fifo_wr_data = scurve_sel ? scan_word : acq_word;
    assign dac_vth      = scurve_sel ? scan_dac : usb_dac_vth;

    // no back-pressure, word dropped while full
    assign fifo_wr_en = src_valid & ~fifo_full;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            overflow <= 1'b0;
        end else if (src_valid && fifo_full) begin
            overflow <= 1'b1;    // held until reset
        end
    end

endmodule

`default_nettype wire

/* rtl/scurve_scan.sv */
`timescale 1ns/1ps
`default_nettype none

module scurve_scan #(
    parameter daq_pkg::dac_t DAC_LAST = '1   // last threshold code of the scan
) (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           test_start,       // strobe, honoured only when idle
    input  daq_pkg::word_t cpt_max,          // window length in clk cycles
    input  logic           trig_b,           // asic trigger out, active low
    output daq_pkg::word_t scan_word,
    output logic           scan_word_valid,
    output daq_pkg::dac_t  scan_dac,         // threshold under test
    output logic           test_done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_STEP,     // new dac code settles
        S_CODE,     // code word out
        S_WINDOW,   // counting triggers
        S_COUNT,    // count word out
        S_DONE
    } state_t;

    state_t         state;
    daq_pkg::word_t timer;      // cycles spent in window
    daq_pkg::word_t trig_cnt;   // triggers seen this step
    logic           trig_q;     // trig_b one cycle late
    logic           trig_fall;

    ////////////////////////////////////////
    // step sequencer
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= S_IDLE;
            scan_dac <= '0;
            timer    <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (test_start) begin
                        state    <= S_STEP;
                        scan_dac <= '0;          // scan always starts at code 0
                    end
                end
                S_STEP: state <= S_CODE;
                S_CODE: begin
                    state <= S_WINDOW;
                    timer <= '0;
                end
                S_WINDOW: begin
                    if (timer == cpt_max - 1'b1) begin
                        state <= S_COUNT;        // exactly cpt_max cycles
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                S_COUNT: begin
                    if (scan_dac == DAC_LAST) begin
                        state <= S_DONE;         // dac holds last code
                    end else begin
                        state    <= S_STEP;
                        scan_dac <= scan_dac + 1'b1;
                    end
                end
                S_DONE:  state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // trigger counter
    ////////////////////////////////////////
    assign trig_fall = trig_q & ~trig_b;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            trig_q   <= 1'b1;    // line idles high
            trig_cnt <= '0;
        end else begin
            trig_q <= trig_b;
            if (state == S_CODE) begin
                trig_cnt <= '0;  // fresh count per step
            end else if (state == S_WINDOW && trig_fall && trig_cnt != '1) begin
                trig_cnt <= trig_cnt + 1'b1;   // saturates at all ones
            end
        end
    end

    // outputs decoded from state
    assign scan_word_valid = (state == S_CODE) || (state == S_COUNT);
    assign scan_word       = (state == S_CODE) ? {daq_pkg::SCAN_TAG, scan_dac} : trig_cnt;
    assign test_done       = (state == S_DONE);

endmodule

`default_nettype wire

/* rtl/acq_readout.sv */
`timescale 1ns/1ps
`default_nettype none

module acq_readout (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           acq_enable,     // level, high for whole acquisition
    input  logic [7:0]     header,         // board id byte from host
    input  logic           dout_b,         // asic ram data, active low
    input  logic           transmiton_b,   // low while dout_b carries a bit
    output daq_pkg::word_t acq_word,
    output logic           acq_word_valid  // one cycle per word
);

    localparam int BIT_W = $clog2(daq_pkg::WORD_W);

    logic             enable_q;      // enable one cycle late
    logic             enable_rise;   // start of acquisition
    logic             bit_take;      // serial bit present this cycle
    logic [BIT_W-1:0] bit_cnt;       // bits already in shift_q
    logic             word_last;     // sixteenth bit arriving
    daq_pkg::word_t   shift_q;
    daq_pkg::word_t   shift_d;

    ////////////////////////////////////////
    // serial bit qualification
    ////////////////////////////////////////
    assign enable_rise = acq_enable & ~enable_q;
    assign bit_take    = acq_enable & ~transmiton_b;
    assign word_last   = bit_take && (bit_cnt == BIT_W'(daq_pkg::WORD_W - 1));

    // msb first, dout_b inverted to true polarity
    assign shift_d = {shift_q[daq_pkg::WORD_W-2:0], ~dout_b};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            enable_q       <= 1'b0;
            bit_cnt        <= '0;
            acq_word_valid <= 1'b0;
        end else begin
            enable_q       <= acq_enable;
            acq_word_valid <= enable_rise | word_last;  // header or full word
            if (!acq_enable) begin
                bit_cnt <= '0;               // partial word thrown away
            end else if (bit_take) begin
                bit_cnt <= bit_cnt + 1'b1;   // wraps to 0 after last bit
            end
        end
    end

    ////////////////////////////////////////
    // payload
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (bit_take) begin
            shift_q <= shift_d;
        end
        if (enable_rise) begin
            acq_word <= {daq_pkg::HEADER_TAG, header};  // acquisition header
        end else if (word_last) begin
            acq_word <= shift_d;                        // includes newest bit
        end
    end

endmodule

`default_nettype wire

/* rtl/daq_pkg.sv */
`default_nettype none

package daq_pkg;

    // usb data path
    localparam int WORD_W = 16;
    typedef logic [WORD_W-1:0] word_t;        // one usb fifo word

    // asic threshold dac
    localparam int DAC_W = 10;
    typedef logic [DAC_W-1:0] dac_t;

    ////////////////////////////////////////
    // word tags
    ////////////////////////////////////////
    localparam logic [7:0] HEADER_TAG = 8'hA5; // upper byte of acq header
    localparam logic [5:0] SCAN_TAG   = 6'h2C; // bits 15..10 of scan code word

    // board running mode
    typedef enum logic {
        MODE_ACQ    = 1'b0,   // asic ram readout
        MODE_SCURVE = 1'b1    // threshold scan
    } mode_t;

endpackage

`default_nettype wire
